/* bench/tb_ps2_mouse.sv */
// testbench for the ps2 mouse subsystem: ps2 device model, reference decode, compare tasks
`timescale 1ns/1ns

module tb_ps2_mouse;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                   clk_sys;
    logic                   rst_n;
    logic                   ps2_clk;
    logic                   ps2_data;
    logic                   report_vld;
    ps2_pkg::mouse_report_t report;
    logic                   sync_err;

    ps2_pkg::mouse_report_t exp_q[$];  // pushed by stimulus, popped by checker
    integer                 seed;

    ps2_mouse_top #(
        .FIFO_DEPTH (ps2_pkg::FIFO_DEPTH_DEFAULT)
    ) UUT (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .report_vld (report_vld),
        .report     (report),
        .sync_err   (sync_err)
    );

    always #10 clk_sys = ~clk_sys;  // 20 ns period

    // mouse byte 0 layout: y_ovf x_ovf y_sign x_sign 1 middle right left
    function automatic ps2_pkg::mouse_report_t expected_report(
        input logic [7:0] b0,
        input logic [7:0] b1,
        input logic [7:0] b2,
        input logic       parity_bad,
        input logic       stop_bad
    );
        ps2_pkg::mouse_report_t r;
        r.buttons   = {b0[0], b0[1], b0[2]};  // left, right, middle
        r.dx        = {b0[4], b1};
        r.dy        = {b0[5], b2};
        r.x_ovf     = b0[6];
        r.y_ovf     = b0[7];
        r.frame_err = parity_bad | stop_bad;
        return r;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_report(
        input string                  name,
        input ps2_pkg::mouse_report_t got,
        input ps2_pkg::mouse_report_t exp
    );
        if (got !== exp) begin
            stop_on_error($sformatf("Fail time=%0t signal=%s got=%h expected=%h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail time=%0t signal=%s got=%b expected=%b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    // one ps2 clock period, data set while the clock is high
    task automatic ps2_bit(input logic b);
        ps2_data = b;
        idle_cycles(10);
        ps2_clk = 1'b0;
        idle_cycles(20);
        ps2_clk = 1'b1;
        idle_cycles(10);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                              input logic bad_stop);
        logic parity;
        parity = ~^data ^ bad_parity;  // odd parity
        ps2_bit(1'b0);                 // start
        for (int i = 0; i < 8; i++) begin
            ps2_bit(data[i]);          // lsb first
        end
        ps2_bit(parity);
        ps2_bit(~bad_stop);
        ps2_data = 1'b1;
        idle_cycles(20);
    endtask

    task automatic send_packet(
        input logic [7:0] b0,
        input logic [7:0] b1,
        input logic [7:0] b2,
        input logic [2:0] bad_par,   // one bit per byte
        input logic [2:0] bad_stop
    );
        exp_q.push_back(expected_report(b0, b1, b2, |bad_par, |bad_stop));
        send_frame(b0, bad_par[0], bad_stop[0]);
        send_frame(b1, bad_par[1], bad_stop[1]);
        send_frame(b2, bad_par[2], bad_stop[2]);
    endtask

    // until every outstanding report has been checked
    task automatic wait_reports();
        int cnt;
        cnt = 0;
        while ((exp_q.size() != 0) && (cnt < TIMEOUT_CYCLES)) begin
            @(negedge clk_sys);
            cnt++;
        end
        if (exp_q.size() != 0) begin
            stop_on_error("Timed out waiting for report_vld after a packet was sent");
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk_sys) begin
        if (rst_n && report_vld) begin
            if (exp_q.size() == 0) begin
                stop_on_error("A report appeared although no packet was outstanding");
            end else begin
                check_report("report", report, exp_q.pop_front());
            end
        end
    end

    initial begin
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        clk_sys  = 1'b0;
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;  // lines idle high
        ps2_data = 1'b1;
        seed     = 32'h5e3c;
        idle_cycles(4);
        rst_n = 1'b1;

        // quiet after reset
        check_flag("report_vld", report_vld, 1'b0);
        check_flag("sync_err", sync_err, 1'b0);
        idle_cycles(500);
        check_flag("sync_err", sync_err, 1'b0);

        repeat (20) begin
            b0 = $random(seed);
            b1 = $random(seed);
            b2 = $random(seed);
            send_packet(b0 | 8'h08, b1, b2, 3'b000, 3'b000);
            wait_reports();
        end
        check_flag("sync_err", sync_err, 1'b0);

        // negative movement, with and without overflow
        send_packet(8'hf9, 8'hf0, 8'h80, 3'b000, 3'b000);
        wait_reports();
        send_packet(8'h3a, 8'h01, 8'hff, 3'b000, 3'b000);
        wait_reports();

        send_packet(8'h0c, 8'h55, 8'h2a, 3'b010, 3'b000);  // middle byte parity
        wait_reports();
        check_flag("sync_err", sync_err, 1'b0);

        // stray byte with bit 3 clear, then a good packet
        send_frame(8'h42, 1'b0, 1'b0);
        check_flag("sync_err", sync_err, 1'b1);
        send_packet(8'h19, 8'h10, 8'h20, 3'b000, 3'b000);
        wait_reports();

        // low stop bit on byte 2 is read as the next start bit
        send_packet(8'h0b, 8'h07, 8'hfe, 3'b000, 3'b100);
        wait_reports();
        // finish that phantom frame: zero data, parity, stop
        repeat (8) begin
            ps2_bit(1'b0);
        end
        ps2_bit(1'b1);
        ps2_bit(1'b1);
        idle_cycles(20);
        send_packet(8'h2e, 8'h33, 8'hc4, 3'b000, 3'b000);  // realigned
        wait_reports();
        check_flag("sync_err", sync_err, 1'b1);

        $display("All checks passed");
        $finish;
    end

endmodule

/* source/mouse_packet_decoder.sv */
// mouse packet aligner, 3-byte assembler and movement report decoder
`timescale 1ns/1ns

module mouse_packet_decoder (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   empty,
    input  ps2_pkg::ps2_byte_t     rd_byte,
    output logic                   pop,
    output logic                   report_vld,  // one cycle per packet
    output ps2_pkg::mouse_report_t report,      // held until next report_vld
    output logic                   sync_err     // sticky until reset
);

    localparam logic [1:0] LAST_IDX = 2'(ps2_pkg::PACKET_BYTES - 1);

    logic                   rd_pend;    // rd_byte valid this cycle
    logic [1:0]             byte_idx;   // slot of the byte now in rd_byte
    logic                   err_acc;    // frame errors of earlier bytes
    ps2_pkg::mouse_packet_u pkt_q;
    ps2_pkg::mouse_packet_u pkt_next;
    logic                   byte_err;
    logic                   err_next;
    logic                   last_byte;
    logic                   misaligned;

    // one read in flight at a time, so at most a byte every two cycles
    assign pop = ~empty & ~rd_pend;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= pop;
        end
    end

    // packet word with the incoming byte dropped into its slot
    always_comb begin
        pkt_next = pkt_q;
        pkt_next.raw[byte_idx] = rd_byte.data;
    end

    assign byte_err  = rd_byte.parity_err | rd_byte.stop_err;
    assign err_next  = ((byte_idx != 2'd0) & err_acc) | byte_err;
    assign last_byte = (byte_idx == LAST_IDX);

    // first byte must carry the marker bit, else it is skipped
    assign misaligned = (byte_idx == 2'd0) & ~pkt_next.fields.always_one;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx   <= 2'd0;
            err_acc    <= 1'b0;
            report_vld <= 1'b0;
            sync_err   <= 1'b0;
        end else begin
            report_vld <= 1'b0;
            if (rd_pend) begin
                if (misaligned) begin
                    sync_err <= 1'b1;  // index stays at 0
                end else if (last_byte) begin
                    byte_idx   <= 2'd0;
                    report_vld <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                    err_acc  <= err_next;
                end
            end
        end
    end

    // assembled word
    always_ff @(posedge clk_sys) begin
        if (rd_pend && !misaligned) begin
            pkt_q <= pkt_next;
        end
    end

    // decode straight from the completed word, saves a cycle
    always_ff @(posedge clk_sys) begin
        if (rd_pend && last_byte) begin
            report.buttons   <= {pkt_next.fields.left,
                                 pkt_next.fields.right,
                                 pkt_next.fields.middle};
            report.dx        <= {pkt_next.fields.x_sign, pkt_next.fields.x_mag};
            report.dy        <= {pkt_next.fields.y_sign, pkt_next.fields.y_mag};
            report.x_ovf     <= pkt_next.fields.x_ovf;
            report.y_ovf     <= pkt_next.fields.y_ovf;
            report.frame_err <= err_next;
        end
    end

endmodule

/* source/ps2_byte_fifo.sv */
// synchronous circular fifo of received ps2 byte records with registered read
`timescale 1ns/1ns

module ps2_byte_fifo #(
    parameter int DEPTH = ps2_pkg::FIFO_DEPTH_DEFAULT  // power of two
) (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  logic               push,
    input  ps2_pkg::ps2_byte_t push_byte,
    input  logic               pop,
    output logic               empty,
    output ps2_pkg::ps2_byte_t rd_byte   // valid the cycle after pop
);

    localparam int AW = $clog2(DEPTH);

    ps2_pkg::ps2_byte_t mem [DEPTH];

    // one extra bit tells full from empty when addresses match
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic full;
    logic do_push;
    logic do_pop;

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign do_push = push & ~full;  // byte lost when full
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_sys) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_byte;
        end
    end

    // read word held until the next pop
    always_ff @(posedge clk_sys) begin
        if (do_pop) begin
            rd_byte <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

/* source/ps2_frame_rx.sv */
// ps2 line synchroniser, falling edge detector and frame fsm with parity and stop checks
`timescale 1ns/1ns

module ps2_frame_rx (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  logic               ps2_clk,   // open collector, idles high
    input  logic               ps2_data,  // open collector, idles high
    output logic               byte_vld,  // one pulse per received frame
    output ps2_pkg::ps2_byte_t rx_byte
);

    // one-hot frame states
    // each state names what the next falling edge of ps2_clk carries
    localparam logic [4:0] ST_IDLE   = 5'b00001;  // waiting for a start bit
    localparam logic [4:0] ST_START  = 5'b00010;  // start seen, data bit 0 next
    localparam logic [4:0] ST_DATA   = 5'b00100;  // data bits 1 to 7
    localparam logic [4:0] ST_PARITY = 5'b01000;
    localparam logic [4:0] ST_STOP   = 5'b10000;

    logic [4:0] state;

    logic [2:0] clk_sync;   // ps2_clk synchroniser chain
    logic       clk_prev;   // last synchronised ps2_clk level
    logic [2:0] data_sync;  // same depth as the clock chain, keeps them aligned
    logic       fall_stb;
    logic       data_bit;

    logic [2:0] bit_cnt;
    logic [7:0] shift_q;
    logic       parity_bit;
    logic       stop_edge;

    // both lines come from another clock domain
    // flops start high so reset release gives no false edge
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;
            clk_prev  <= 1'b1;
            data_sync <= 3'b111;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            clk_prev  <= clk_sync[2];
            data_sync <= {data_sync[1:0], ps2_data};
        end
    end

    // strobe shows up 3 clk_sys cycles after the line falls
    assign fall_stb = clk_prev & ~clk_sync[2];
    assign data_bit = data_sync[2];  // device changes data while clock is high

    assign stop_edge = fall_stb && (state == ST_STOP);

    // frame sequencing, advances only on ps2_clk falling edges
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= 3'd0;
        end else if (fall_stb) begin
            case (state)
                ST_IDLE: begin
                    if (!data_bit) begin
                        state <= ST_START;  // start bit is a 0
                    end
                end
                ST_START: begin
                    state   <= ST_DATA;
                    bit_cnt <= 3'd1;  // bit 0 taken on this edge
                end
                ST_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= ST_PARITY;
                    end
                end
                ST_PARITY: begin
                    state <= ST_STOP;
                end
                ST_STOP: begin
                    // a low line here is taken as the next start bit
                    if (!data_bit) begin
                        state <= ST_START;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // data comes in lsb first, so shift toward the lsb
    always_ff @(posedge clk_sys) begin
        if (fall_stb && ((state == ST_START) || (state == ST_DATA))) begin
            shift_q <= {data_bit, shift_q[7:1]};
        end
        if (fall_stb && (state == ST_PARITY)) begin
            parity_bit <= data_bit;
        end
    end

    // byte strobe on the edge after the stop bit sample
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            byte_vld <= 1'b0;
        end else begin
            byte_vld <= stop_edge;
        end
    end

    // odd parity: data ones plus parity bit must be odd
    // so a parity bit equal to the data xor is a failure
    always_ff @(posedge clk_sys) begin
        if (stop_edge) begin
            rx_byte.data       <= shift_q;
            rx_byte.parity_err <= (parity_bit == ^shift_q);
            rx_byte.stop_err   <= ~data_bit;
        end
    end

endmodule

/* source/ps2_mouse_top.sv */
// ps2 mouse input top: frame receiver, byte fifo and packet decoder
`timescale 1ns/1ns

module ps2_mouse_top #(
    parameter int FIFO_DEPTH = ps2_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    output logic                   report_vld,
    output ps2_pkg::mouse_report_t report,
    output logic                   sync_err
);

    logic               byte_vld;
    ps2_pkg::ps2_byte_t rx_byte;
    logic               fifo_empty;
    ps2_pkg::ps2_byte_t rd_byte;
    logic               pop;

    ps2_frame_rx u_frame_rx (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .byte_vld (byte_vld),
        .rx_byte  (rx_byte)
    );

    // absorbs bursts while the decoder works
    ps2_byte_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .push      (byte_vld),
        .push_byte (rx_byte),
        .pop       (pop),
        .empty     (fifo_empty),
        .rd_byte   (rd_byte)
    );

    mouse_packet_decoder u_decoder (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .empty      (fifo_empty),
        .rd_byte    (rd_byte),
        .pop        (pop),
        .report_vld (report_vld),
        .report     (report),
        .sync_err   (sync_err)
    );

endmodule

/* source/ps2_pkg.sv */
// ps2 shared constants, received byte record, mouse packet union and report struct
package ps2_pkg;

    // bytes in one standard mouse movement packet
    localparam int PACKET_BYTES = 3;

    // default depth of the byte buffer, power of two
    localparam int FIFO_DEPTH_DEFAULT = 8;

    // one received ps2 frame with its own error flags
    typedef struct packed {
        logic [7:0] data;        // payload, first received bit in lsb
        logic       parity_err;  // odd parity check failed
        logic       stop_err;    // stop bit sampled low
    } ps2_byte_t;

    // assembled packet word
    // written byte by byte through raw, decoded through fields
    typedef union packed {
        logic [PACKET_BYTES-1:0][7:0] raw;  // raw[0] is byte 0, low bits

        struct packed {
            // byte 2
            logic [7:0] y_mag;
            // byte 1
            logic [7:0] x_mag;
            // byte 0, bit 7 down to bit 0
            logic       y_ovf;
            logic       x_ovf;
            logic       y_sign;
            logic       x_sign;
            logic       always_one;  // alignment marker, set in every byte 0
            logic       middle;
            logic       right;
            logic       left;
        } fields;
    } mouse_packet_u;

    // decoded movement report, one per packet
    typedef struct packed {
        logic [2:0]        buttons;    // {left, right, middle}
        logic signed [8:0] dx;         // sign bit from byte 0, magnitude from byte 1
        logic signed [8:0] dy;         // positive is upward movement
        logic              x_ovf;
        logic              y_ovf;
        logic              frame_err;  // any of the three bytes had a bad frame
    } mouse_report_t;

endpackage

/* verilog.f */
source/ps2_pkg.sv
source/ps2_frame_rx.sv
source/ps2_byte_fifo.sv
source/mouse_packet_decoder.sv
source/ps2_mouse_top.sv
bench/tb_ps2_mouse.sv
